/* Makefile */
SIM = obj_dir/VtbSigmoid

.PHONY: run clean

run: $(SIM)
	$(SIM) | tee sim.log
	grep -qx "test passed" sim.log

$(SIM): filelist.f $(wildcard logic/*.sv logic/*.svh tests/*.sv)
	verilator --binary --timing --assert -f filelist.f --top-module tbSigmoid -o VtbSigmoid

clean:
	rm -rf obj_dir sim.log

/* filelist.f */
+incdir+logic
logic/sigmoidTypesPkg.sv
logic/sigmoidTablePkg.sv
logic/sigmoidDecode.sv
logic/sigmoidExecute.sv
logic/sigmoidResult.sv
logic/sigmoid.sv
tests/sigmoidChecker.sv
tests/tbSigmoid.sv

/* logic/sigmoid.sv */
`include "sigmoid_macros.svh"

module sigmoid (
	input  logic                                clk,
	input  logic                                i_arstN,
	input  logic signed [`SIGMOID_X_W-1:0]      i_x,
	input  logic                                i_xValid,
	output logic                                o_xCredit,
	output logic [`SIGMOID_Y_W-1:0]             o_y,
	output logic                                o_yValid,
	input  logic                                i_yCredit
);

	sigmoidTypesPkg::decodedSample_t decoded;
	sigmoidTypesPkg::productSample_t product;

	// Magnitude, sign and segment pick
	sigmoidDecode decode_i (
		.clk        (clk),
		.i_arstN    (i_arstN),
		.i_x        (i_x),
		.i_xValid   (i_xValid),
		.o_decoded  (decoded)
	);

	// Slope times magnitude plus intercept
	sigmoidExecute execute_i (
		.clk        (clk),
		.i_arstN    (i_arstN),
		.i_decoded  (decoded),
		.o_product  (product)
	);

	// Sign fold, result FIFO and both credit sides
	sigmoidResult result_i (
		.clk        (clk),
		.i_arstN    (i_arstN),
		.i_product  (product),
		.i_yCredit  (i_yCredit),
		.o_y        (o_y),
		.o_yValid   (o_yValid),
		.o_xCredit  (o_xCredit)
	);

endmodule

/* logic/sigmoidDecode.sv */
`include "sigmoid_macros.svh"

module sigmoidDecode (
	input  logic                                clk,
	input  logic                                i_arstN,
	input  logic signed [`SIGMOID_X_W-1:0]      i_x,
	input  logic                                i_xValid,
	output sigmoidTypesPkg::decodedSample_t     o_decoded
);

	localparam int MagW = `SIGMOID_MAG_W;

	logic [`SIGMOID_X_W-1:0] negX;
	logic [`SIGMOID_X_W-1:0] absX;
	logic [MagW-1:0] magnitude;
	sigmoidTypesPkg::segment_e segment;

	// Negating -128 wraps to 8'h80 which reads as 128
	assign negX = ~i_x + 1'b1;
	assign absX = i_x[`SIGMOID_X_W-1] ? negX : i_x;
	assign magnitude = MagW'(absX);

	// Only 128 has the top bit set and it shares the last segment
	always_comb begin
		if (magnitude[MagW-1]) begin
			segment = sigmoidTypesPkg::SEG7;
		end else begin
			segment = sigmoidTypesPkg::segment_e'(magnitude[6:4]);
		end
	end

	always_ff @(posedge clk or negedge i_arstN) begin
		if (!i_arstN) begin
			o_decoded <= '0;
		end else begin
			o_decoded.valid <= i_xValid;
			o_decoded.sign <= i_x[`SIGMOID_X_W-1];
			o_decoded.magnitude <= magnitude;
			o_decoded.segment <= segment;
		end
	end

	// Anything above 128 means the negate went wrong
	magnitudeRange: assert property (
		@(posedge clk) disable iff (!i_arstN)
		o_decoded.valid |-> (o_decoded.magnitude <= MagW'(128))
	) else $error("decoded magnitude %0d above 128", o_decoded.magnitude);

endmodule

/* logic/sigmoidExecute.sv */
`include "sigmoid_macros.svh"

module sigmoidExecute (
	input  logic                                clk,
	input  logic                                i_arstN,
	input  sigmoidTypesPkg::decodedSample_t     i_decoded,
	output sigmoidTypesPkg::productSample_t     o_product
);

	localparam int SumW = `SIGMOID_SUM_W;

	logic [`SIGMOID_SLOPE_W-1:0] slope;
	logic [SumW-1:0] intercept;
	logic [SumW-1:0] product;
	logic [SumW-1:0] sum;

	// Coefficient lookup
	assign slope = sigmoidTablePkg::slopeTable[i_decoded.segment];
	assign intercept = sigmoidTablePkg::interceptTable[i_decoded.segment];

	// 8x4 product fits in 12 bits, the add may carry out and is dropped
	assign product = SumW'(i_decoded.magnitude) * SumW'(slope);
	assign sum = product + intercept;

	always_ff @(posedge clk or negedge i_arstN) begin
		if (!i_arstN) begin
			o_product <= '0;
		end else begin
			o_product.valid <= i_decoded.valid;
			o_product.sign <= i_decoded.sign;
			o_product.sum <= sum;
		end
	end

endmodule

/* logic/sigmoidResult.sv */
`include "sigmoid_macros.svh"

module sigmoidResult (
	input  logic                                clk,
	input  logic                                i_arstN,
	input  sigmoidTypesPkg::productSample_t     i_product,
	input  logic                                i_yCredit,
	output logic [`SIGMOID_Y_W-1:0]             o_y,
	output logic                                o_yValid,
	output logic                                o_xCredit
);

	localparam int Depth = `SIGMOID_FIFO_DEPTH;
	localparam int PtrW = $clog2(Depth);
	localparam int CountW = $clog2(Depth + 1);
	localparam int CreditW = `SIGMOID_CREDIT_W;

	logic [`SIGMOID_VAL_W-1:0] foldedVal;
	logic [`SIGMOID_Y_W-1:0] resultWord;
	logic [`SIGMOID_Y_W-1:0] fifoMem [Depth];
	logic [PtrW-1:0] wrPtr;
	logic [PtrW-1:0] rdPtr;
	logic [CountW-1:0] fifoCount;
	logic [CreditW-1:0] creditCnt;
	logic fifoFull;
	logic fifoEmpty;
	logic push;
	logic pop;

	// Negative inputs give 1 - f(|x|), which is the bitwise inverse here
	assign foldedVal = i_product.sum[`SIGMOID_VAL_W-1:0] ^ {`SIGMOID_VAL_W{i_product.sign}};
	assign resultWord = {1'b0, foldedVal, 4'b0000};

	assign fifoFull = (fifoCount == CountW'(Depth));
	assign fifoEmpty = (fifoCount == '0);

	// No stall path, the producer credits keep room for every valid sample
	assign push = i_product.valid;
	assign pop = !fifoEmpty && (creditCnt != '0);

	assign o_y = fifoMem[rdPtr];
	assign o_yValid = pop;
	// Each slot freed goes straight back to the producer
	assign o_xCredit = pop;

	always_ff @(posedge clk) begin
		if (push) begin
			fifoMem[wrPtr] <= resultWord;
		end
	end

	// Depth is a power of two so the pointers wrap by themselves
	always_ff @(posedge clk or negedge i_arstN) begin
		if (!i_arstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			fifoCount <= '0;
		end else begin
			if (push) begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (pop) begin
				rdPtr <= rdPtr + 1'b1;
			end
			if (push && !pop) begin
				fifoCount <= fifoCount + 1'b1;
			end else if (pop && !push) begin
				fifoCount <= fifoCount - 1'b1;
			end
		end
	end

	// Output credits, a grant and a send in one cycle cancel
	always_ff @(posedge clk or negedge i_arstN) begin
		if (!i_arstN) begin
			creditCnt <= '0;
		end else begin
			case ({i_yCredit, pop})
				2'b10: creditCnt <= creditCnt + 1'b1;
				2'b01: creditCnt <= creditCnt - 1'b1;
				default: creditCnt <= creditCnt;
			endcase
		end
	end

	// Producer broke the credit contract
	noPushWhenFull: assert property (
		@(posedge clk) disable iff (!i_arstN)
		push |-> (!fifoFull || pop)
	) else $error("push into full result FIFO");

	creditNoOverflow: assert property (
		@(posedge clk) disable iff (!i_arstN)
		(i_yCredit && !pop) |-> (creditCnt != '1)
	) else $error("output credit counter overflow");

	// Spending the last credit with nothing new must stop the output
	lastCreditStops: assert property (
		@(posedge clk) disable iff (!i_arstN)
		(o_yValid && !i_yCredit && creditCnt == CreditW'(1)) |=> !o_yValid
	) else $error("o_yValid high with zero output credits");

endmodule

/* logic/sigmoidTablePkg.sv */
`include "sigmoid_macros.svh"

package sigmoidTablePkg;

	// Slope per segment, fraction of 2^-3 down to 2^-6
	parameter logic [`SIGMOID_SLOPE_W-1:0] slopeTable [8] = '{
		4'd15,
		4'd14,
		4'd11,
		4'd8,
		4'd6,
		4'd4,
		4'd2,
		4'd1
	};

	// Intercept per segment
	// Top two bits are always 01, so every value sits around one half
	parameter logic [`SIGMOID_SUM_W-1:0] interceptTable [8] = '{
		12'd1027,
		12'd1053,
		12'd1150,
		12'd1295,
		12'd1419,
		12'd1572,
		12'd1762,
		12'd1880
	};

endpackage

/* logic/sigmoidTypesPkg.sv */
`include "sigmoid_macros.svh"

package sigmoidTypesPkg;

	// Eight linear pieces over the input magnitude
	typedef enum logic [2:0] {
		SEG0,
		SEG1,
		SEG2,
		SEG3,
		SEG4,
		SEG5,
		SEG6,
		SEG7
	} segment_e;

	// Decode to execute
	typedef struct packed {
		logic                          valid;
		logic                          sign;
		logic [`SIGMOID_MAG_W-1:0]     magnitude;
		segment_e                      segment;
	} decodedSample_t;

	// Execute to result
	typedef struct packed {
		logic                          valid;
		logic                          sign;
		logic [`SIGMOID_SUM_W-1:0]     sum;
	} productSample_t;

endpackage

/* logic/sigmoid_macros.svh */
`ifndef SIGMOID_MACROS_SVH
`define SIGMOID_MACROS_SVH

// Signed input sample
`define SIGMOID_X_W 8
// Result word, value lives in bits 14:4
`define SIGMOID_Y_W 16
// Magnitude has to hold 128 for the most negative input
`define SIGMOID_MAG_W 8
`define SIGMOID_SLOPE_W 4
// Multiply-add result, also the intercept width
`define SIGMOID_SUM_W 12
`define SIGMOID_VAL_W 11

// Result FIFO and credit flow control
`define SIGMOID_FIFO_DEPTH 4
`define SIGMOID_CREDIT_W 3

`endif

/* tests/sigmoidChecker.sv */
`include "sigmoid_macros.svh"

module sigmoidChecker #(
	parameter int NumSamples = 400
) (
	input  logic                            clk,
	input  logic                            i_arstN,
	input  logic signed [`SIGMOID_X_W-1:0]  i_x,
	input  logic                            i_xValid,
	input  logic                            i_xCredit,
	input  logic [`SIGMOID_Y_W-1:0]         i_y,
	input  logic                            i_yValid,
	input  logic                            i_yCredit,
	input  logic                            i_endOfTest,
	input  logic                            i_timedOut,
	output int                              o_errorCount,
	output logic                            o_reportDone
);

	// Coefficients per segment, SEG0 first
	localparam int SlopeTable [8] = '{15, 14, 11, 8, 6, 4, 2, 1};
	localparam int InterceptTable [8] = '{1027, 1053, 1150, 1295, 1419, 1572, 1762, 1880};

	logic [`SIGMOID_Y_W-1:0] expectedQ [$];
	logic [`SIGMOID_Y_W-1:0] expected;
	int samples = 0;
	int results = 0;
	int yCredits = 0;
	int xCredits = 0;
	int mismatches = 0;
	int protocolErrors = 0;
	int endErrors = 0;
	logic reportDone = 1'b0;

	assign o_errorCount = mismatches + protocolErrors + endErrors;
	assign o_reportDone = reportDone;

	function automatic logic [`SIGMOID_Y_W-1:0] modelWord(
		input logic signed [`SIGMOID_X_W-1:0] x
	);
		int mag;
		int seg;
		int sum;
		logic [`SIGMOID_VAL_W-1:0] val;
		mag = (x < 0) ? -int'(x) : int'(x);
		// 128 is the only magnitude past the last boundary
		seg = (mag >= 128) ? 7 : mag / 16;
		sum = mag * SlopeTable[3'(seg)] + InterceptTable[3'(seg)];
		// Low 11 bits, inverted for negative inputs
		val = (x < 0) ? ~sum[`SIGMOID_VAL_W-1:0] : sum[`SIGMOID_VAL_W-1:0];
		return {1'b0, val, 4'b0000};
	endfunction

	task automatic finalReport();
		if (i_timedOut) begin
			$display("ERROR: timeout, the cycle limit was reached before all results arrived");
			endErrors++;
		end
		if (expectedQ.size() != 0) begin
			$display("ERROR: %0d expected results never came out", expectedQ.size());
			endErrors++;
		end
		if (samples != NumSamples || results != NumSamples || xCredits != NumSamples) begin
			$display("ERROR: %0d samples, %0d results, %0d input credits, wanted %0d each",
				samples, results, xCredits, NumSamples);
			endErrors++;
		end
		$display("errors: %0d mismatches, %0d protocol, %0d end of run",
			mismatches, protocolErrors, endErrors);
		reportDone = 1'b1;
	endtask

	// Mid-cycle sampling, everything is settled here
	always @(negedge clk) begin
		if (i_arstN === 1'b1) begin
			if (i_xValid) begin
				expectedQ.push_back(modelWord(i_x));
				samples++;
			end
			if (i_yValid) begin
				results++;
				// Only credits granted in earlier cycles can be spent
				if (results > yCredits) begin
					$display("ERROR: o_yValid at %0t without an output credit", $time);
					protocolErrors++;
				end
				if (i_y[15] || i_y[3:0] != 4'h0) begin
					$display("MISMATCH time=%0t signal=o_y[15],o_y[3:0] got=%h expected=0",
						$time, {i_y[15], i_y[3:0]});
					mismatches++;
				end
				if (expectedQ.size() == 0) begin
					$display("ERROR: result at %0t with no sample outstanding", $time);
					protocolErrors++;
				end else begin
					expected = expectedQ.pop_front();
					if (i_y !== expected) begin
						$display("MISMATCH time=%0t signal=o_y got=%h expected=%h",
							$time, i_y, expected);
						mismatches++;
					end
				end
			end
			if (i_yCredit) begin
				yCredits++;
			end
			if (i_xCredit) begin
				xCredits++;
			end
			if (i_endOfTest && !reportDone) begin
				finalReport();
			end
		end
	end

endmodule

/* tests/tbSigmoid.sv */
`include "sigmoid_macros.svh"

module tbSigmoid;

	localparam int NumSamples = 400;
	// Worst case of 20 cycles per sample
	localparam int TimeoutCycles = NumSamples * 20;
	localparam int WithholdAt = 150;
	localparam int WithholdCycles = 200;
	// Keeps the 3-bit output credit counter from wrapping
	localparam int MaxOutstanding = 6;
	localparam int NumDirected = 20;

	// Zero, both ends, then segment boundaries on both signs
	localparam logic signed [`SIGMOID_X_W-1:0] Directed [NumDirected] = '{
		8'sd0, 8'sd127, -8'sd1, 8'sh80, 8'sd16, 8'sd32, 8'sd48, 8'sd64, 8'sd80, 8'sd96,
		8'sd112, -8'sd16, -8'sd32, -8'sd48, -8'sd64, -8'sd80, -8'sd96, -8'sd112, 8'sd15, -8'sd127
	};

	logic clk = 1'b0;
	logic i_arstN;
	logic signed [`SIGMOID_X_W-1:0] i_x;
	logic i_xValid;
	logic o_xCredit;
	logic [`SIGMOID_Y_W-1:0] o_y;
	logic o_yValid;
	logic i_yCredit;
	logic endOfTest;
	logic timedOut = 1'b0;
	logic reportDone;
	int errorCount;
	int cycleCount = 0;
	logic [15:0] lfsrState;

	// Fibonacci LFSR, taps 16 14 13 11, one step per bit taken
	function automatic int unsigned randBits(input int n);
		int unsigned value;
		logic feedback;
		value = 0;
		for (int i = 0; i < n; i++) begin
			feedback = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
			lfsrState = {lfsrState[14:0], feedback};
			value = (value << 1) | {31'd0, lfsrState[0]};
		end
		return value;
	endfunction

	function automatic logic signed [`SIGMOID_X_W-1:0] nextSample(input int idx);
		int unsigned bits;
		if (idx < NumDirected) begin
			return Directed[5'(idx)];
		end
		bits = randBits(`SIGMOID_X_W);
		return bits[`SIGMOID_X_W-1:0];
	endfunction

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TimeoutCycles) begin
			timedOut <= 1'b1;
		end
	end

	sigmoid sigmoid_i (.*);

	sigmoidChecker #(.NumSamples(NumSamples)) check_i (
		.*,
		.i_xCredit(o_xCredit), .i_y(o_y), .i_yValid(o_yValid),
		.i_endOfTest(endOfTest), .i_timedOut(timedOut),
		.o_errorCount(errorCount), .o_reportDone(reportDone)
	);

	initial begin
		int xCredits;
		int outstanding;
		int sentCount;
		int resultsSeen;
		int withholdLeft;
		logic withheldDone;
		logic creditBack;
		logic resultOut;
		i_arstN = 1'b0;
		i_x = '0;
		i_xValid = 1'b0;
		i_yCredit = 1'b0;
		endOfTest = 1'b0;
		lfsrState = 16'd24;
		xCredits = `SIGMOID_FIFO_DEPTH;
		outstanding = 0;
		sentCount = 0;
		resultsSeen = 0;
		withholdLeft = 0;
		withheldDone = 1'b0;
		repeat (16) @(posedge clk);
		i_arstN <= 1'b1;
		while (resultsSeen < NumSamples && !timedOut) begin
			// Handshake outputs read mid-cycle, acted on at the next rising edge
			@(negedge clk);
			creditBack = o_xCredit;
			resultOut = o_yValid;
			@(posedge clk);
			if (creditBack) begin
				xCredits++;
			end
			if (resultOut) begin
				outstanding--;
				resultsSeen++;
			end
			// Producer spends one credit per sample
			if (sentCount < NumSamples && xCredits > 0 && randBits(1) == 1) begin
				i_x <= nextSample(sentCount);
				i_xValid <= 1'b1;
				xCredits--;
				sentCount++;
			end else begin
				i_xValid <= 1'b0;
			end
			// One long stretch without output credits once the stream runs
			if (!withheldDone && sentCount >= WithholdAt) begin
				withholdLeft = WithholdCycles;
				withheldDone = 1'b1;
			end
			if (withholdLeft > 0) begin
				withholdLeft--;
				i_yCredit <= 1'b0;
			end else if (outstanding < MaxOutstanding && randBits(2) != 0) begin
				i_yCredit <= 1'b1;
				outstanding++;
			end else begin
				i_yCredit <= 1'b0;
			end
		end
		i_xValid <= 1'b0;
		i_yCredit <= 1'b0;
		// Room for a stray output before the closing checks
		repeat (8) @(posedge clk);
		endOfTest <= 1'b1;
		while (!reportDone) begin
			@(posedge clk);
		end
		if (errorCount == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule
